//--- verilog.f
hw/rom_map_pkg.sv
hw/input_map_pkg.sv
hw/rom_loader.sv
hw/rom_bank.sv
hw/program_rom.sv
hw/player_inputs.sv
hw/gauntlet_io.sv
tb/gauntlet_io_props.sv
tb/gauntlet_io_tb.sv

//--- Makefile
TOP = gauntlet_io_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- tb/gauntlet_io_tb.sv
// Gauntlet system glue testbench
`timescale 1ns/1ps

module gauntlet_io_tb;

	logic                                 clk_sys;
	logic                                 rst;
	rom_map_pkg::ioctl_t                  ioctl;
	input_map_pkg::ps2_key_t              key;
	logic [15:0]                          joy0;
	logic [15:0]                          joy1;
	logic [15:0]                          joy2;
	logic [15:0]                          joy3;
	logic                                 service;
	logic [rom_map_pkg::PROG_WORD_AW-1:0] prog_addr;
	logic [rom_map_pkg::ROM_DW-1:0]       prog_data;
	input_map_pkg::player_bus_t           players;

	int                         seed = 23;
	logic                       check_on;
	logic [15:0]                rom_model [int];  // Program word address to data
	int                         read_q [$];       // Word addresses written
	logic [24:0]                byte_q [$];       // Odd byte addresses written
	logic [7:0]                 last_byte;        // Previous index 0 byte
	logic [35:0]                lat;              // Key model, p1 p2 p3 p4 then coins
	logic                       tgl_q;
	logic [7:0]                 game_m;
	int                         slot;
	input_map_pkg::player_bus_t exp_players;

	// Key per latch slot, 9'h1FF marks an empty slot
	logic [8:0] std_keys [36] = '{
		input_map_pkg::KEY_STD_P1_MAGIC, input_map_pkg::KEY_STD_P1_FIRE, 9'h1FF, 9'h1FF,
		input_map_pkg::KEY_STD_P1_RIGHT, input_map_pkg::KEY_STD_P1_LEFT,
		input_map_pkg::KEY_STD_P1_DOWN, input_map_pkg::KEY_STD_P1_UP,
		input_map_pkg::KEY_STD_P2_MAGIC, input_map_pkg::KEY_STD_P2_FIRE, 9'h1FF, 9'h1FF,
		input_map_pkg::KEY_STD_P2_RIGHT, input_map_pkg::KEY_STD_P2_LEFT,
		input_map_pkg::KEY_STD_P2_DOWN, input_map_pkg::KEY_STD_P2_UP,
		input_map_pkg::KEY_STD_P3_MAGIC, input_map_pkg::KEY_STD_P3_FIRE, 9'h1FF, 9'h1FF,
		input_map_pkg::KEY_STD_P3_RIGHT, input_map_pkg::KEY_STD_P3_LEFT,
		input_map_pkg::KEY_STD_P3_DOWN, input_map_pkg::KEY_STD_P3_UP,
		input_map_pkg::KEY_STD_P4_MAGIC, input_map_pkg::KEY_STD_P4_FIRE, 9'h1FF, 9'h1FF,
		input_map_pkg::KEY_STD_P4_RIGHT, input_map_pkg::KEY_STD_P4_LEFT,
		input_map_pkg::KEY_STD_P4_DOWN, input_map_pkg::KEY_STD_P4_UP,
		input_map_pkg::KEY_COIN1, input_map_pkg::KEY_COIN2,
		input_map_pkg::KEY_COIN3, input_map_pkg::KEY_COIN4
	};
	logic [8:0] tank_keys [36] = '{
		input_map_pkg::KEY_TANK_P1_L_TRIG, input_map_pkg::KEY_TANK_P1_R_TRIG,
		input_map_pkg::KEY_TANK_P1_L_THUMB, input_map_pkg::KEY_TANK_P1_R_THUMB,
		input_map_pkg::KEY_TANK_P1_L_FORW, input_map_pkg::KEY_TANK_P1_R_FORW,
		input_map_pkg::KEY_TANK_P1_L_BACK, input_map_pkg::KEY_TANK_P1_R_BACK,
		input_map_pkg::KEY_TANK_P2_L_TRIG, input_map_pkg::KEY_TANK_P2_R_TRIG,
		input_map_pkg::KEY_TANK_P2_L_THUMB, input_map_pkg::KEY_TANK_P2_R_THUMB,
		input_map_pkg::KEY_TANK_P2_L_FORW, input_map_pkg::KEY_TANK_P2_R_FORW,
		input_map_pkg::KEY_TANK_P2_L_BACK, input_map_pkg::KEY_TANK_P2_R_BACK,
		input_map_pkg::KEY_TANK_P1_START, input_map_pkg::KEY_TANK_P2_START,
		9'h1FF, 9'h1FF, 9'h1FF, 9'h1FF, 9'h1FF, 9'h1FF,
		9'h1FF, 9'h1FF, 9'h1FF, 9'h1FF, 9'h1FF, 9'h1FF, 9'h1FF, 9'h1FF,
		input_map_pkg::KEY_COIN1, input_map_pkg::KEY_COIN2, 9'h1FF, 9'h1FF
	};
	// Up down left right; nine table rows, then one illegal combination
	logic [3:0] dirs [10] = '{4'b1000, 4'b1010, 4'b1001, 4'b0001, 4'b0100,
		4'b0101, 4'b0110, 4'b0010, 4'b0000, 4'b1100};

	gauntlet_io dut0 (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ioctl     (ioctl),
		.key       (key),
		.joy0      (joy0),
		.joy1      (joy1),
		.joy2      (joy2),
		.joy3      (joy3),
		.service   (service),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.players   (players)
	);

	bind rom_loader gauntlet_io_props props0 (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ioctl   (ioctl),
		.rom_wr  (rom_wr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;  // 4 ns period
	end

	// ########################################
	// Reference model
	// Download byte address to program word address, -1 for filler or outside
	function automatic int rom_region_of(input logic [24:0] a);
		if (a >= 25'h0C0000 && a < 25'h0D0000) return int'({4'b0000, a[15:1]});  // 9A/9B
		if (a >= 25'h0F0000 && a < 25'h0F8000) return int'({5'b00110, a[14:1]}); // 10A/10B
		if (a >= 25'h100000 && a < 25'h110000) return int'({4'b0100, a[15:1]});  // 7A/7B
		if (a >= 25'h110000 && a < 25'h120000) return int'({4'b0101, a[15:1]});  // 6A/6B
		if (a >= 25'h120000 && a < 25'h130000) return int'({4'b0110, a[15:1]});  // 5A/5B
		if (a >= 25'h130000 && a < 25'h140000) return int'({4'b0111, a[15:1]});  // 3A/3B
		return -1;
	endfunction

	function automatic logic [15:0] expected_word(input int waddr);
		return rom_model.exists(waddr) ? rom_model[waddr] : 16'h0000;  // Unwritten reads 0
	endfunction

	function automatic int key_slot(input logic [8:0] code, input logic tank);
		if (code == 9'h1FF)
			return -1;
		for (int s = 0; s < 36; s++)
			if ((tank ? tank_keys[s] : std_keys[s]) == code)
				return s;
		return -1;  // Not in this map
	endfunction

	// Direction to {right back, left back, right fwd, left fwd}
	function automatic logic [3:0] tread_levels(input logic [3:0] dir);
		logic [3:0] t;  // Table order, lf lb rf rb
		case (dir)
			4'b1000: t = 4'b1010;  // Up
			4'b1010: t = 4'b0010;  // Up left
			4'b1001: t = 4'b1000;  // Up right
			4'b0001: t = 4'b1001;  // Right
			4'b0100: t = 4'b0101;  // Down
			4'b0101: t = 4'b0100;  // Down right
			4'b0110: t = 4'b0001;  // Down left
			4'b0010: t = 4'b0110;  // Left
			default: t = 4'b0000;
		endcase
		return {t[0], t[2], t[1], t[3]};
	endfunction

	function automatic input_map_pkg::player_bus_t expected_players(
		input logic [35:0] kl,
		input logic [15:0] j0,
		input logic [15:0] j1,
		input logic [15:0] j2,
		input logic [15:0] j3,
		input logic        svc,
		input logic        tank
	);
		input_map_pkg::player_bus_t p;
		p.sys.service = ~svc;
		p.sys.coin1   = ~(kl[32] | j0[input_map_pkg::JOY_COIN]);
		p.sys.coin2   = ~(kl[33] | j1[input_map_pkg::JOY_COIN]);
		p.sys.coin3   = ~(kl[34] | j2[input_map_pkg::JOY_COIN]);
		p.sys.coin4   = ~(kl[35] | j3[input_map_pkg::JOY_COIN]);
		if (tank) begin
			p.p1 = ~(kl[7:0] | {tread_levels(j0[3:0]), j0[7:4]});
			p.p2 = ~(kl[15:8] | {tread_levels(j1[3:0]), j1[7:4]});
			p.p3 = ~(kl[23:16] | {6'b0, j1[input_map_pkg::JOY_START],
				j0[input_map_pkg::JOY_START]});
			p.p4 = ~kl[31:24];
		end else begin
			p.p1 = ~(kl[7:0] | {j0[3:0], j0[7:4]});  // Up down left right, buttons
			p.p2 = ~(kl[15:8] | {j1[3:0], j1[7:4]});
			p.p3 = ~(kl[23:16] | {j2[3:0], j2[7:4]});
			p.p4 = ~(kl[31:24] | {j3[3:0], j3[7:4]});
		end
		return p;
	endfunction

	// Model state advances on the same edges as the DUT
	always @(posedge clk_sys) begin
		if (rst) begin
			lat         = '0;
			tgl_q       = 1'b0;
			game_m      = input_map_pkg::GAME_GAUNTLET;
			exp_players = '1;
		end else begin
			exp_players = expected_players(lat, joy0, joy1, joy2, joy3, service,
				game_m == input_map_pkg::GAME_VINDICATORS);
			if (key.toggle != tgl_q) begin
				slot = key_slot(key.code, game_m == input_map_pkg::GAME_VINDICATORS);
				if (slot >= 0)
					lat[slot] = key.pressed;
			end
			tgl_q = key.toggle;
			if (ioctl.wr && ioctl.index == input_map_pkg::DL_INDEX_GAME)
				game_m = ioctl.dout;
		end
	end

	always @(negedge clk_sys) begin
		if (check_on)
			check(64'(players), 64'(exp_players), "player bus");  // Midcycle, stable
	end

	// ########################################
	// Checks and stimulus
	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1, "stopping on first error");
		end
	endtask

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic send_byte(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		int waddr;
		ioctl.wr    = 1'b1;
		ioctl.index = index;
		ioctl.addr  = addr;
		ioctl.dout  = data;
		if (index == input_map_pkg::DL_INDEX_ROM && ioctl.download) begin
			waddr = rom_region_of(addr);
			if (addr[0] && waddr >= 0) begin
				rom_model[waddr] = {last_byte, data};  // Earlier byte is high half
				read_q.push_back(waddr);
				byte_q.push_back(addr);
			end else if (addr[0]) begin
				// Filler byte, read back where a loose decode would land
				read_q.push_back(rom_region_of(addr & ~25'h038000));
			end
			last_byte = data;
		end
		tick();
		ioctl.wr = 1'b0;
	endtask

	// Even/odd byte pairs at random even offsets
	task automatic send_pairs(input logic [24:0] base, input logic [24:0] size, input int n);
		int r;
		logic [24:0] off;
		for (int i = 0; i < n; i++) begin
			r   = $random(seed);
			off = 25'(r) & (size - 25'd2);
			send_byte(input_map_pkg::DL_INDEX_ROM, base + off, r[15:8]);
			send_byte(input_map_pkg::DL_INDEX_ROM, base + off + 25'd1, r[23:16]);
		end
	endtask

	task automatic read_check(input int waddr);
		prog_addr = waddr[18:0];
		tick();  // Data one cycle after the address
		check(64'(prog_data), 64'(expected_word(waddr)), $sformatf("read at %h", waddr));
	endtask

	task automatic press_key(input logic [8:0] code, input logic pressed);
		key.toggle  = ~key.toggle;
		key.pressed = pressed;
		key.code    = code;
		tick();
	endtask

	function automatic logic [8:0] random_code(input logic tank);
		int idx;
		logic [8:0] c;
		idx = $unsigned($random(seed)) % 36;
		c   = tank ? tank_keys[idx] : std_keys[idx];
		if (c == 9'h1FF)
			c = std_keys[idx];  // Tank mode gets standard-only codes here
		return c;
	endfunction

	task automatic random_inputs(input int steps, input logic tank);
		int pick;
		int r;
		for (int i = 0; i < steps; i++) begin
			pick = $unsigned($random(seed)) % 10;
			r    = $random(seed);
			case (pick)
				0, 1, 2, 3: begin
					key.toggle  = ~key.toggle;
					key.pressed = r[0];  // Release clears the bit
					key.code    = random_code(tank);
				end
				4: joy0 = r[15:0];
				5: joy1 = r[15:0];
				6: joy2 = r[15:0];
				7: joy3 = r[15:0];
				8: service = r[0];
				default: ;  // Idle cycle
			endcase
			tick();
		end
	endtask

	initial begin
		int r;
		ioctl     = '0;
		key       = '0;
		joy0      = '0;
		joy1      = '0;
		joy2      = '0;
		joy3      = '0;
		service   = 1'b0;
		prog_addr = '0;
		rst       = 1'b1;
		check_on  = 1'b0;
		last_byte = '0;
		for (int i = 0; i < 10; i++)
			tick();
		rst      = 1'b0;
		check_on = 1'b1;
		check(64'(players), {27'd0, 37'h1F_FFFF_FFFF}, "players after reset");
		for (int i = 0; i < 8; i++)
			read_check(int'($unsigned($random(seed)) % (1 << 19)));

		// Download into all six windows and both filler ranges
		ioctl.download = 1'b1;
		send_pairs(rom_map_pkg::DL_BASE_9A_9B, 25'h010000, 16);
		send_pairs(25'h0D0000, 25'h020000, 8);  // Filler 0D0000 to 0EFFFF
		send_pairs(rom_map_pkg::DL_BASE_10A_10B, 25'h008000, 16);
		send_pairs(25'h0F8000, 25'h008000, 8);  // Filler 0F8000 to 0FFFFF
		send_pairs(rom_map_pkg::DL_BASE_7A_7B, 25'h010000, 16);
		send_pairs(rom_map_pkg::DL_BASE_6A_6B, 25'h010000, 16);
		send_pairs(rom_map_pkg::DL_BASE_5A_5B, 25'h010000, 16);
		send_pairs(rom_map_pkg::DL_BASE_3A_3B, 25'h010000, 16);
		tick();
		ioctl.download = 1'b0;
		foreach (read_q[i])
			read_check(read_q[i]);
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			read_check(32'h08000 + (r & 32'h3FFF));  // Unmapped regions
			read_check(32'h10000 + (r & 32'h3FFF));
			read_check(32'h1C000 + (r & 32'h3FFF));
			read_check(32'h40000 + (r & 32'h3FFFF));
		end

		// Index 2 over written words, then the variant byte
		ioctl.download = 1'b1;
		for (int i = 0; i < 12; i++) begin
			r = $unsigned($random(seed)) % byte_q.size();
			send_byte(8'd2, byte_q[r] - 25'd1, 8'hA5);
			send_byte(8'd2, byte_q[r], 8'h5A);
		end
		tick();
		ioctl.download = 1'b0;
		foreach (read_q[i])
			read_check(read_q[i]);

		random_inputs(400, 1'b0);  // Standard map
		// Release every standard key so the treads are not masked
		for (int s = 0; s < 36; s++)
			if (std_keys[s] != 9'h1FF)
				press_key(std_keys[s], 1'b0);
		send_byte(input_map_pkg::DL_INDEX_GAME, 25'd0, 8'd118);
		tick();

		// Tank mode, every direction row on both sticks
		for (int d = 0; d < 10; d++) begin
			r         = $random(seed);
			joy0      = r[15:0];
			joy0[3:0] = dirs[d];
			joy1      = r[31:16];
			joy1[3:0] = dirs[9 - d];
			tick();
			tick();
		end
		press_key(input_map_pkg::KEY_STD_P1_UP, 1'b1);  // Arrows ignored here
		press_key(input_map_pkg::KEY_STD_P1_LEFT, 1'b1);
		press_key(input_map_pkg::KEY_STD_P4_FIRE, 1'b1);
		random_inputs(300, 1'b1);
		tick();
		tick();
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- tb/gauntlet_io_props.sv
// Loader write assertions
`timescale 1ns/1ps

module gauntlet_io_props (
	input logic                 clk_sys,
	input logic                 rst,
	input rom_map_pkg::ioctl_t  ioctl,
	input rom_map_pkg::rom_wr_t rom_wr
);

	// ########################################
	// Write pulse only right after a strobe
	write_needs_strobe: assert property (
		@(posedge clk_sys) disable iff (rst)
		!ioctl.wr |=> !rom_wr.valid
	) else $error("ROM write in the cycle after a cycle without a strobe");

	// Strobe cycle was inside a download
	write_in_download: assert property (
		@(posedge clk_sys) disable iff (rst)
		rom_wr.valid |-> $past(ioctl.download)
	) else $error("ROM write from a byte sent while download was low");

	bank_legal: assert property (
		@(posedge clk_sys) disable iff (rst)
		rom_wr.bank inside {rom_map_pkg::BANK_9A_9B, rom_map_pkg::BANK_10A_10B,
			rom_map_pkg::BANK_7A_7B, rom_map_pkg::BANK_6A_6B,
			rom_map_pkg::BANK_5A_5B, rom_map_pkg::BANK_3A_3B}
	) else $error("ROM write bank is not a legal bank value");

endmodule

//--- hw/gauntlet_io.sv
// Gauntlet system glue top
`timescale 1ns/1ps

module gauntlet_io (
	input  logic                                 clk_sys,
	input  logic                                 rst,
	input  rom_map_pkg::ioctl_t                  ioctl,
	input  input_map_pkg::ps2_key_t              key,
	input  logic [15:0]                          joy0,
	input  logic [15:0]                          joy1,
	input  logic [15:0]                          joy2,
	input  logic [15:0]                          joy3,
	input  logic                                 service,
	input  logic [rom_map_pkg::PROG_WORD_AW-1:0] prog_addr,
	output logic [rom_map_pkg::ROM_DW-1:0]       prog_data,
	output input_map_pkg::player_bus_t           players
);

	rom_map_pkg::rom_wr_t rom_wr;  // Loader to banks
	input_map_pkg::game_e game;    // Variant from download index 1

	rom_loader u_loader (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ioctl   (ioctl),
		.rom_wr  (rom_wr),
		.game    (game)
	);

	program_rom u_prog_rom (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.rom_wr    (rom_wr),
		.prog_addr (prog_addr),
		.prog_data (prog_data)
	);

	player_inputs u_inputs (
		.clk_sys (clk_sys),
		.rst     (rst),
		.game    (game),
		.key     (key),
		.joy0    (joy0),
		.joy1    (joy1),
		.joy2    (joy2),
		.joy3    (joy3),
		.service (service),
		.players (players)
	);

endmodule

//--- hw/player_inputs.sv
// Keyboard and joystick input merge
`timescale 1ns/1ps

module player_inputs (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  input_map_pkg::game_e        game,
	input  input_map_pkg::ps2_key_t     key,
	input  logic [15:0]                 joy0,
	input  logic [15:0]                 joy1,
	input  logic [15:0]                 joy2,
	input  logic [15:0]                 joy3,
	input  logic                        service,
	output input_map_pkg::player_bus_t  players
);

	logic                        key_tgl_q;
	logic                        key_event;
	logic                        tank;  // Vindicators key map and treads
	input_map_pkg::player_word_t p1_k;  // Key latches, active high
	input_map_pkg::player_word_t p2_k;
	input_map_pkg::player_word_t p3_k;
	input_map_pkg::player_word_t p4_k;
	logic [3:0]                  coin_k;
	logic [3:0]                  tread0;
	logic [3:0]                  tread1;

	// Up down left right in, {R back, L back, R fwd, L fwd} out
	function automatic logic [3:0] tread_of(input logic [3:0] dir);
		case (dir)
			4'b1000: return 4'b0011;  // Up
			4'b1010: return 4'b0010;  // Up left
			4'b1001: return 4'b0001;  // Up right
			4'b0001: return 4'b1001;  // Right, spin
			4'b0100: return 4'b1100;  // Down
			4'b0101: return 4'b0100;  // Down right
			4'b0110: return 4'b1000;  // Down left
			4'b0010: return 4'b0110;  // Left, spin
			default: return 4'b0000;
		endcase
	endfunction

	assign tank      = game == input_map_pkg::GAME_VINDICATORS;
	assign key_event = key.toggle != key_tgl_q;
	assign tread0    = tread_of(joy0[3:0]);
	assign tread1    = tread_of(joy1[3:0]);

	// ########################################
	// Key latch
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			key_tgl_q <= 1'b0;
			p1_k      <= '0;
			p2_k      <= '0;
			p3_k      <= '0;
			p4_k      <= '0;
			coin_k    <= '0;
		end else begin
			key_tgl_q <= key.toggle;
			if (key_event && tank) begin
				case (key.code)
					input_map_pkg::KEY_TANK_P1_R_BACK:  p1_k[7] <= key.pressed;
					input_map_pkg::KEY_TANK_P1_L_BACK:  p1_k[6] <= key.pressed;
					input_map_pkg::KEY_TANK_P1_R_FORW:  p1_k[5] <= key.pressed;
					input_map_pkg::KEY_TANK_P1_L_FORW:  p1_k[4] <= key.pressed;
					input_map_pkg::KEY_TANK_P1_R_THUMB: p1_k[3] <= key.pressed;
					input_map_pkg::KEY_TANK_P1_L_THUMB: p1_k[2] <= key.pressed;
					input_map_pkg::KEY_TANK_P1_R_TRIG:  p1_k[1] <= key.pressed;
					input_map_pkg::KEY_TANK_P1_L_TRIG:  p1_k[0] <= key.pressed;
					input_map_pkg::KEY_TANK_P2_R_BACK:  p2_k[7] <= key.pressed;
					input_map_pkg::KEY_TANK_P2_L_BACK:  p2_k[6] <= key.pressed;
					input_map_pkg::KEY_TANK_P2_R_FORW:  p2_k[5] <= key.pressed;
					input_map_pkg::KEY_TANK_P2_L_FORW:  p2_k[4] <= key.pressed;
					input_map_pkg::KEY_TANK_P2_R_THUMB: p2_k[3] <= key.pressed;
					input_map_pkg::KEY_TANK_P2_L_THUMB: p2_k[2] <= key.pressed;
					input_map_pkg::KEY_TANK_P2_R_TRIG:  p2_k[1] <= key.pressed;
					input_map_pkg::KEY_TANK_P2_L_TRIG:  p2_k[0] <= key.pressed;
					input_map_pkg::KEY_TANK_P1_START:   p3_k[0] <= key.pressed;
					input_map_pkg::KEY_TANK_P2_START:   p3_k[1] <= key.pressed;
					input_map_pkg::KEY_COIN1:           coin_k[0] <= key.pressed;
					input_map_pkg::KEY_COIN2:           coin_k[1] <= key.pressed;
					default: ;  // Other codes ignored in tank mode
				endcase
			end else if (key_event) begin
				case (key.code)
					input_map_pkg::KEY_STD_P1_UP:    p1_k[7] <= key.pressed;
					input_map_pkg::KEY_STD_P1_DOWN:  p1_k[6] <= key.pressed;
					input_map_pkg::KEY_STD_P1_LEFT:  p1_k[5] <= key.pressed;
					input_map_pkg::KEY_STD_P1_RIGHT: p1_k[4] <= key.pressed;
					input_map_pkg::KEY_STD_P1_FIRE:  p1_k[1] <= key.pressed;
					input_map_pkg::KEY_STD_P1_MAGIC: p1_k[0] <= key.pressed;
					input_map_pkg::KEY_STD_P2_UP:    p2_k[7] <= key.pressed;
					input_map_pkg::KEY_STD_P2_DOWN:  p2_k[6] <= key.pressed;
					input_map_pkg::KEY_STD_P2_LEFT:  p2_k[5] <= key.pressed;
					input_map_pkg::KEY_STD_P2_RIGHT: p2_k[4] <= key.pressed;
					input_map_pkg::KEY_STD_P2_FIRE:  p2_k[1] <= key.pressed;
					input_map_pkg::KEY_STD_P2_MAGIC: p2_k[0] <= key.pressed;
					input_map_pkg::KEY_STD_P3_UP:    p3_k[7] <= key.pressed;
					input_map_pkg::KEY_STD_P3_DOWN:  p3_k[6] <= key.pressed;
					input_map_pkg::KEY_STD_P3_LEFT:  p3_k[5] <= key.pressed;
					input_map_pkg::KEY_STD_P3_RIGHT: p3_k[4] <= key.pressed;
					input_map_pkg::KEY_STD_P3_FIRE:  p3_k[1] <= key.pressed;
					input_map_pkg::KEY_STD_P3_MAGIC: p3_k[0] <= key.pressed;
					input_map_pkg::KEY_STD_P4_UP:    p4_k[7] <= key.pressed;
					input_map_pkg::KEY_STD_P4_DOWN:  p4_k[6] <= key.pressed;
					input_map_pkg::KEY_STD_P4_LEFT:  p4_k[5] <= key.pressed;
					input_map_pkg::KEY_STD_P4_RIGHT: p4_k[4] <= key.pressed;
					input_map_pkg::KEY_STD_P4_FIRE:  p4_k[1] <= key.pressed;
					input_map_pkg::KEY_STD_P4_MAGIC: p4_k[0] <= key.pressed;
					input_map_pkg::KEY_COIN1:        coin_k[0] <= key.pressed;
					input_map_pkg::KEY_COIN2:        coin_k[1] <= key.pressed;
					input_map_pkg::KEY_COIN3:        coin_k[2] <= key.pressed;
					input_map_pkg::KEY_COIN4:        coin_k[3] <= key.pressed;
					default: ;
				endcase
			end
		end
	end

	// ########################################
	// Merge with joysticks, active low out
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			players <= '1;  // Nothing pressed
		end else begin
			players.sys.service <= ~service;
			players.sys.coin1   <= ~(coin_k[0] | joy0[input_map_pkg::JOY_COIN]);
			players.sys.coin2   <= ~(coin_k[1] | joy1[input_map_pkg::JOY_COIN]);
			players.sys.coin3   <= ~(coin_k[2] | joy2[input_map_pkg::JOY_COIN]);
			players.sys.coin4   <= ~(coin_k[3] | joy3[input_map_pkg::JOY_COIN]);
			if (tank) begin
				players.p1 <= ~(p1_k | {tread0, joy0[7:4]});
				players.p2 <= ~(p2_k | {tread1, joy1[7:4]});
				players.p3 <= ~(p3_k | {6'b0, joy1[input_map_pkg::JOY_START],
					joy0[input_map_pkg::JOY_START]});
				players.p4 <= ~p4_k;  // Keys only
			end else begin
				players.p1 <= ~(p1_k | {joy0[3:0], joy0[7:4]});  // Up down left right, buttons
				players.p2 <= ~(p2_k | {joy1[3:0], joy1[7:4]});
				players.p3 <= ~(p3_k | {joy2[3:0], joy2[7:4]});
				players.p4 <= ~(p4_k | {joy3[3:0], joy3[7:4]});
			end
		end
	end

endmodule

//--- hw/program_rom.sv
// Program ROM and read mux
`timescale 1ns/1ps

module program_rom (
	input  logic                                 clk_sys,
	input  logic                                 rst,
	input  rom_map_pkg::rom_wr_t                 rom_wr,
	input  logic [rom_map_pkg::PROG_WORD_AW-1:0] prog_addr,
	output logic [rom_map_pkg::ROM_DW-1:0]       prog_data
);

	localparam int TOP = rom_map_pkg::PROG_WORD_AW - 1;

	logic [4:0]                     rd_region;  // prog_addr[18:14] of the read in flight
	logic [rom_map_pkg::ROM_DW-1:0] bank_q [6];

	// Six banks, indexed by prog_bank_e
	for (genvar i = 0; i < 6; i++) begin : g_bank
		localparam int AW = (i == int'(rom_map_pkg::BANK_10A_10B)) ?
			rom_map_pkg::BANK_AW_NARROW : rom_map_pkg::BANK_AW_WIDE;

		rom_bank #(.AW(AW)) u_bank (
			.clk_sys (clk_sys),
			.wr_en   (rom_wr.valid && rom_wr.bank == rom_map_pkg::prog_bank_e'(i)),
			.wr_addr (rom_wr.addr[AW-1:0]),
			.wr_data (rom_wr.data),
			.rd_addr (prog_addr[AW-1:0]),
			.rd_data (bank_q[i])
		);
	end

	// Region follows the bank read by one cycle
	always_ff @(posedge clk_sys) begin
		if (rst)
			rd_region <= rom_map_pkg::REGION_NONE;
		else
			rd_region <= prog_addr[TOP:TOP-4];
	end

	// ########################################
	// Read mux, 10A/10B decoded on five bits
	always_comb begin
		if (rd_region[4:1] == rom_map_pkg::REGION_9A_9B)
			prog_data = bank_q[rom_map_pkg::BANK_9A_9B];
		else if (rd_region == rom_map_pkg::REGION_10A_10B)
			prog_data = bank_q[rom_map_pkg::BANK_10A_10B];
		else if (rd_region[4:1] == rom_map_pkg::REGION_7A_7B)
			prog_data = bank_q[rom_map_pkg::BANK_7A_7B];
		else if (rd_region[4:1] == rom_map_pkg::REGION_6A_6B)
			prog_data = bank_q[rom_map_pkg::BANK_6A_6B];
		else if (rd_region[4:1] == rom_map_pkg::REGION_5A_5B)
			prog_data = bank_q[rom_map_pkg::BANK_5A_5B];
		else if (rd_region[4:1] == rom_map_pkg::REGION_3A_3B)
			prog_data = bank_q[rom_map_pkg::BANK_3A_3B];
		else
			prog_data = '0;  // Unmapped
	end

endmodule

//--- hw/rom_bank.sv
// Program ROM bank
`timescale 1ns/1ps

module rom_bank #(
	parameter int AW = 15
) (
	input  logic                           clk_sys,
	input  logic                           wr_en,
	input  logic [AW-1:0]                  wr_addr,
	input  logic [rom_map_pkg::ROM_DW-1:0] wr_data,
	input  logic [AW-1:0]                  rd_addr,
	output logic [rom_map_pkg::ROM_DW-1:0] rd_data
);

	logic [rom_map_pkg::ROM_DW-1:0] mem [2**AW];

	// Power-up contents zero, unloaded words read 0
	initial begin
		for (int i = 0; i < 2**AW; i++)
			mem[i] = '0;
	end

	always @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;  // Download port
	end

	always_ff @(posedge clk_sys)
		rd_data <= mem[rd_addr];  // CPU port, one cycle latency

endmodule

//--- hw/rom_loader.sv
// ROM download decoder
`timescale 1ns/1ps

module rom_loader (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  rom_map_pkg::ioctl_t  ioctl,
	output rom_map_pkg::rom_wr_t rom_wr,
	output input_map_pkg::game_e game
);

	logic [7:0]              acc;         // Previous ROM byte, becomes high half
	logic                    rom_strobe;  // Index 0 byte during download
	logic                    win_hit;
	rom_map_pkg::prog_bank_e win_bank;
	logic [24:0]             win_offset;  // Byte offset inside the window

	function automatic logic [24:0] base_of(input rom_map_pkg::prog_bank_e bank);
		case (bank)
			rom_map_pkg::BANK_10A_10B: return rom_map_pkg::DL_BASE_10A_10B;
			rom_map_pkg::BANK_7A_7B:   return rom_map_pkg::DL_BASE_7A_7B;
			rom_map_pkg::BANK_6A_6B:   return rom_map_pkg::DL_BASE_6A_6B;
			rom_map_pkg::BANK_5A_5B:   return rom_map_pkg::DL_BASE_5A_5B;
			rom_map_pkg::BANK_3A_3B:   return rom_map_pkg::DL_BASE_3A_3B;
			default:                   return rom_map_pkg::DL_BASE_9A_9B;
		endcase
	endfunction

	function automatic logic in_window(
		input logic [24:0]             addr,
		input rom_map_pkg::prog_bank_e bank
	);
		logic [24:0] size;
		// Only 10A/10B is half size, the rest of its 64K is filler
		size = (bank == rom_map_pkg::BANK_10A_10B) ?
			rom_map_pkg::DL_SIZE_NARROW : rom_map_pkg::DL_SIZE_WIDE;
		return addr >= base_of(bank) && addr < base_of(bank) + size;
	endfunction

	// ########################################
	// Window decode
	assign rom_strobe = ioctl.wr && ioctl.download &&
		ioctl.index == input_map_pkg::DL_INDEX_ROM;

	always_comb begin
		win_hit  = 1'b0;
		win_bank = rom_map_pkg::BANK_9A_9B;
		for (int i = 0; i < 6; i++) begin
			if (in_window(ioctl.addr, rom_map_pkg::prog_bank_e'(i))) begin
				win_hit  = 1'b1;
				win_bank = rom_map_pkg::prog_bank_e'(i);
			end
		end
	end

	assign win_offset = ioctl.addr - base_of(win_bank);

	// ########################################
	// Word write and game variant
	always_ff @(posedge clk_sys) begin
		rom_wr.bank <= win_bank;  // Payload, qualified by valid
		rom_wr.addr <= win_offset[15:1];
		rom_wr.data <= {acc, ioctl.dout};  // Even byte high, odd byte low
		if (rst) begin
			acc          <= '0;
			rom_wr.valid <= 1'b0;
			game         <= input_map_pkg::GAME_GAUNTLET;
		end else begin
			rom_wr.valid <= rom_strobe && ioctl.addr[0] && win_hit;  // One cycle pulse
			if (rom_strobe)
				acc <= ioctl.dout;
			if (ioctl.wr && ioctl.index == input_map_pkg::DL_INDEX_GAME)
				game <= input_map_pkg::game_e'(ioctl.dout);
		end
	end

endmodule

//--- hw/input_map_pkg.sv
// Player input map
package input_map_pkg;

	typedef enum logic [7:0] {
		GAME_GAUNTLET    = 8'd104,
		GAME_GAUNTLET2   = 8'd106,
		GAME_GAUNTLET_2P = 8'd107,
		GAME_VINDICATORS = 8'd118  // Tank controls
	} game_e;

	localparam logic [7:0] DL_INDEX_ROM  = 8'd0;
	localparam logic [7:0] DL_INDEX_GAME = 8'd1;

	// ########################################
	// Standard four-player map
	localparam logic [8:0] KEY_STD_P1_UP    = 9'h175;  // Arrows
	localparam logic [8:0] KEY_STD_P1_DOWN  = 9'h172;
	localparam logic [8:0] KEY_STD_P1_LEFT  = 9'h16B;
	localparam logic [8:0] KEY_STD_P1_RIGHT = 9'h174;
	localparam logic [8:0] KEY_STD_P1_FIRE  = 9'h014;  // Left ctrl
	localparam logic [8:0] KEY_STD_P1_MAGIC = 9'h011;  // Left alt
	localparam logic [8:0] KEY_STD_P2_UP    = 9'h02D;  // R F D G
	localparam logic [8:0] KEY_STD_P2_DOWN  = 9'h02B;
	localparam logic [8:0] KEY_STD_P2_LEFT  = 9'h023;
	localparam logic [8:0] KEY_STD_P2_RIGHT = 9'h034;
	localparam logic [8:0] KEY_STD_P2_FIRE  = 9'h01C;  // A
	localparam logic [8:0] KEY_STD_P2_MAGIC = 9'h01B;  // S
	localparam logic [8:0] KEY_STD_P3_UP    = 9'h043;  // I K J L
	localparam logic [8:0] KEY_STD_P3_DOWN  = 9'h042;
	localparam logic [8:0] KEY_STD_P3_LEFT  = 9'h03B;
	localparam logic [8:0] KEY_STD_P3_RIGHT = 9'h04B;
	localparam logic [8:0] KEY_STD_P3_FIRE  = 9'h114;  // Right ctrl
	localparam logic [8:0] KEY_STD_P3_MAGIC = 9'h059;  // Right shift
	localparam logic [8:0] KEY_STD_P4_UP    = 9'h075;  // Numpad 8 2 4 6
	localparam logic [8:0] KEY_STD_P4_DOWN  = 9'h072;
	localparam logic [8:0] KEY_STD_P4_LEFT  = 9'h06B;
	localparam logic [8:0] KEY_STD_P4_RIGHT = 9'h074;
	localparam logic [8:0] KEY_STD_P4_FIRE  = 9'h070;  // Numpad 0
	localparam logic [8:0] KEY_STD_P4_MAGIC = 9'h071;  // Numpad dot

	// Coins, both maps; tank map uses 1 and 2 only
	localparam logic [8:0] KEY_COIN1 = 9'h02E;  // 5
	localparam logic [8:0] KEY_COIN2 = 9'h036;  // 6
	localparam logic [8:0] KEY_COIN3 = 9'h03D;  // 7
	localparam logic [8:0] KEY_COIN4 = 9'h03E;  // 8

	// ########################################
	// Vindicators tank map
	localparam logic [8:0] KEY_TANK_P1_R_BACK  = 9'h023;  // D
	localparam logic [8:0] KEY_TANK_P1_L_BACK  = 9'h01B;  // S
	localparam logic [8:0] KEY_TANK_P1_R_FORW  = 9'h024;  // E
	localparam logic [8:0] KEY_TANK_P1_L_FORW  = 9'h01D;  // W
	localparam logic [8:0] KEY_TANK_P1_R_THUMB = 9'h02D;  // R
	localparam logic [8:0] KEY_TANK_P1_L_THUMB = 9'h015;  // Q
	localparam logic [8:0] KEY_TANK_P1_R_TRIG  = 9'h02B;  // F
	localparam logic [8:0] KEY_TANK_P1_L_TRIG  = 9'h01C;  // A
	localparam logic [8:0] KEY_TANK_P2_R_BACK  = 9'h042;  // K
	localparam logic [8:0] KEY_TANK_P2_L_BACK  = 9'h03B;  // J
	localparam logic [8:0] KEY_TANK_P2_R_FORW  = 9'h043;  // I
	localparam logic [8:0] KEY_TANK_P2_L_FORW  = 9'h03C;  // U
	localparam logic [8:0] KEY_TANK_P2_R_THUMB = 9'h044;  // O
	localparam logic [8:0] KEY_TANK_P2_L_THUMB = 9'h035;  // Y
	localparam logic [8:0] KEY_TANK_P2_R_TRIG  = 9'h04B;  // L
	localparam logic [8:0] KEY_TANK_P2_L_TRIG  = 9'h033;  // H
	localparam logic [8:0] KEY_TANK_P1_START   = 9'h016;  // 1
	localparam logic [8:0] KEY_TANK_P2_START   = 9'h01E;  // 2

	// Joystick word bits; 3:0 up down left right order reversed, 7:4 buttons
	localparam int JOY_COIN  = 8;
	localparam int JOY_START = 9;

	typedef struct packed {
		logic       toggle;   // Flips on every event
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	typedef logic [7:0] player_word_t;  // Active low

	typedef struct packed {
		logic service;
		logic coin1;
		logic coin2;
		logic coin3;
		logic coin4;
	} sys_word_t;  // Active low

	typedef struct packed {
		player_word_t p1;
		player_word_t p2;
		player_word_t p3;
		player_word_t p4;
		sys_word_t    sys;
	} player_bus_t;

endpackage

//--- hw/rom_map_pkg.sv
// ROM download map
package rom_map_pkg;

	localparam int PROG_WORD_AW   = 19;  // CPU program word address
	localparam int BANK_AW_WIDE   = 15;  // 32K words per bank
	localparam int BANK_AW_NARROW = 14;  // 16K words, 10A/10B only
	localparam int ROM_DW         = 16;

	typedef enum logic [2:0] {
		BANK_9A_9B,
		BANK_10A_10B,
		BANK_7A_7B,
		BANK_6A_6B,
		BANK_5A_5B,
		BANK_3A_3B
	} prog_bank_e;

	// ########################################
	// Download windows, byte addresses
	localparam logic [24:0] DL_BASE_9A_9B   = 25'h0C0000;
	localparam logic [24:0] DL_BASE_10A_10B = 25'h0F0000;  // Filler behind it up to 0FFFFF
	localparam logic [24:0] DL_BASE_7A_7B   = 25'h100000;
	localparam logic [24:0] DL_BASE_6A_6B   = 25'h110000;
	localparam logic [24:0] DL_BASE_5A_5B   = 25'h120000;
	localparam logic [24:0] DL_BASE_3A_3B   = 25'h130000;
	localparam logic [24:0] DL_SIZE_WIDE    = 25'h010000;  // 64 KB
	localparam logic [24:0] DL_SIZE_NARROW  = 25'h008000;  // 32 KB

	// ########################################
	// Read regions, prog_addr[18:15] or [18:14]
	localparam logic [3:0] REGION_9A_9B   = 4'b0000;
	localparam logic [4:0] REGION_10A_10B = 5'b00110;
	localparam logic [3:0] REGION_7A_7B   = 4'b0100;
	localparam logic [3:0] REGION_6A_6B   = 4'b0101;
	localparam logic [3:0] REGION_5A_5B   = 4'b0110;
	localparam logic [3:0] REGION_3A_3B   = 4'b0111;
	localparam logic [4:0] REGION_NONE    = 5'b11111;  // Unmapped, reads zero

	typedef struct packed {
		logic        download;  // Level, high during transfer
		logic        wr;        // Byte strobe
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  dout;
	} ioctl_t;

	typedef struct packed {
		logic                    valid;
		prog_bank_e              bank;
		logic [BANK_AW_WIDE-1:0] addr;  // Word address within bank
		logic [ROM_DW-1:0]       data;
	} rom_wr_t;

endpackage
